// ==== cache2axi/cache_to_axi.sv ====
// Turns each cache DMA packet into one AXI4 incrementing burst
// One packet in flight, write beats and read beats stream through

`timescale 1ns/1ps

module cache_to_axi
 #(parameter int beats_p = 4)
  (input                                clk_i
   , input                              rst_n_i

   , input dma_axi_pkg::dma_pkt_s       dma_pkt_i
   , input                              dma_pkt_v_i
   , output logic                       dma_pkt_ready_and_o

   // Write beats from the splitter
   , input dma_axi_pkg::axi_data_t      wbeat_i
   , input                              wbeat_v_i
   , output logic                       wbeat_yumi_o

   // Read beats to the gatherer
   , output dma_axi_pkg::axi_data_t     rbeat_o
   , output logic                       rbeat_v_o
   , input                              rbeat_ready_and_i

   , output dma_axi_pkg::axi_addr_req_s m_axi_ar_o
   , output logic                       m_axi_arvalid_o
   , input                              m_axi_arready_i

   , input dma_axi_pkg::axi_data_t      m_axi_rdata_i
   , input dma_axi_pkg::axi_resp_t      m_axi_rresp_i
   , input                              m_axi_rlast_i
   , input                              m_axi_rvalid_i
   , output logic                       m_axi_rready_o

   , output dma_axi_pkg::axi_addr_req_s m_axi_aw_o
   , output logic                       m_axi_awvalid_o
   , input                              m_axi_awready_i

   , output dma_axi_pkg::axi_data_t     m_axi_wdata_o
   , output logic                       m_axi_wlast_o
   , output logic                       m_axi_wvalid_o
   , input                              m_axi_wready_i

   , input dma_axi_pkg::axi_resp_t      m_axi_bresp_i
   , input                              m_axi_bvalid_i
   , output logic                       m_axi_bready_o
   );

  import dma_axi_pkg::*;

  localparam int wcnt_width_lp = (beats_p > 1) ? $clog2(beats_p) : 1;

  c2a_state_e               state_q;
  c2a_state_e               state_n;
  dma_addr_t                addr_q;
  axi_addr_req_s            addr_req;
  logic [wcnt_width_lp-1:0] wcnt_q;
  logic                     err_q;

  logic pkt_take;
  logic ar_hs;
  logic r_hs;
  logic aw_hs;
  logic w_hs;
  logic b_hs;

  // Same burst shape for both directions
  assign addr_req.addr = addr_q;
  assign addr_req.len  = axi_len_t'(beats_p-1);
  assign m_axi_ar_o = addr_req;
  assign m_axi_aw_o = addr_req;

  // A bus error parks the bridge until reset
  // A full read block still waiting for the cache also holds off the next packet
  assign dma_pkt_ready_and_o = (state_q == e_c2a_idle) & rbeat_ready_and_i & ~err_q;
  assign pkt_take = dma_pkt_v_i & dma_pkt_ready_and_o;

  assign m_axi_arvalid_o = (state_q == e_c2a_rd_addr);
  assign ar_hs = m_axi_arvalid_o & m_axi_arready_i;

  // Read beats pass straight through
  assign rbeat_o = m_axi_rdata_i;
  assign rbeat_v_o = (state_q == e_c2a_rd_data) & m_axi_rvalid_i;
  assign m_axi_rready_o = (state_q == e_c2a_rd_data) & rbeat_ready_and_i;
  assign r_hs = m_axi_rvalid_i & m_axi_rready_o;

  assign m_axi_awvalid_o = (state_q == e_c2a_wr_addr);
  assign aw_hs = m_axi_awvalid_o & m_axi_awready_i;

  assign m_axi_wdata_o = wbeat_i;
  assign m_axi_wvalid_o = (state_q == e_c2a_wr_data) & wbeat_v_i;
  assign m_axi_wlast_o = (wcnt_q == wcnt_width_lp'(beats_p-1));
  assign w_hs = m_axi_wvalid_o & m_axi_wready_i;
  assign wbeat_yumi_o = w_hs;

  assign m_axi_bready_o = (state_q == e_c2a_wr_resp);
  assign b_hs = m_axi_bvalid_i & m_axi_bready_o;

  always_comb
  begin
    state_n = state_q;
    case (state_q)
      e_c2a_idle:
        if (pkt_take)
          state_n = dma_pkt_i.write_not_read ? e_c2a_wr_addr : e_c2a_rd_addr;
      e_c2a_rd_addr:
        if (ar_hs)
          state_n = e_c2a_rd_data;
      e_c2a_rd_data:
        if (r_hs & m_axi_rlast_i)
          state_n = e_c2a_idle;
      e_c2a_wr_addr:
        if (aw_hs)
          state_n = e_c2a_wr_data;
      e_c2a_wr_data:
        if (w_hs & m_axi_wlast_o)
          state_n = e_c2a_wr_resp;
      e_c2a_wr_resp:
        if (b_hs)
          state_n = e_c2a_idle;
      default:
        state_n = e_c2a_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= e_c2a_idle;
      wcnt_q  <= '0;
      err_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_n;
      if (w_hs)
        wcnt_q <= m_axi_wlast_o ? '0 : wcnt_q + wcnt_width_lp'(1);
      // SLVERR or DECERR on either response channel
      if ((r_hs & m_axi_rresp_i[1]) | (b_hs & m_axi_bresp_i[1]))
        err_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pkt_take)
      addr_q <= dma_pkt_i.addr;
  end

endmodule

// ==== common/dma_axi_pkg.sv ====
// Shared widths, types and state encoding for the DMA to AXI4 memory path
// Modules import this package inside their bodies

package dma_axi_pkg;

  // One AXI data beat
  localparam int axi_data_width_c = 64;

  // Byte address on both the DMA and AXI sides
  localparam int dma_addr_width_c = 32;

  // AXI4 burst length field
  localparam int axi_len_width_c = 8;

  typedef logic [axi_data_width_c-1:0] axi_data_t;
  typedef logic [dma_addr_width_c-1:0] dma_addr_t;
  typedef logic [axi_len_width_c-1:0]  axi_len_t;

  // OKAY, EXOKAY, SLVERR, DECERR
  typedef logic [1:0] axi_resp_t;

  // Cache DMA request, always one full block
  typedef struct packed
  {
    logic      write_not_read;
    dma_addr_t addr;
  } dma_pkt_s;

  // AR or AW payload, incrementing burst implied
  typedef struct packed
  {
    dma_addr_t addr;
    axi_len_t  len;
  } axi_addr_req_s;

  // Bridge FSM
  typedef enum logic [2:0]
  {
    e_c2a_idle
    , e_c2a_rd_addr
    , e_c2a_rd_data
    , e_c2a_wr_addr
    , e_c2a_wr_data
    , e_c2a_wr_resp
  } c2a_state_e;

endpackage

// ==== rtl/dma_axi_top.sv ====
// Cache DMA port to AXI4 memory master, one burst per block
// Write blocks are split into beats, read beats are gathered into blocks

`timescale 1ns/1ps

module dma_axi_top
 #(parameter int beats_p = 4)
  (input                                          clk_i
   , input                                        rst_n_i

   // Cache DMA side
   , input dma_axi_pkg::dma_pkt_s                 dma_pkt_i
   , input                                        dma_pkt_v_i
   , output logic                                 dma_pkt_ready_and_o

   , input dma_axi_pkg::axi_data_t [beats_p-1:0]  dma_data_i
   , input                                        dma_data_v_i
   , output logic                                 dma_data_ready_and_o

   , output dma_axi_pkg::axi_data_t [beats_p-1:0] dma_data_o
   , output logic                                 dma_data_v_o
   , input                                        dma_data_ready_and_i

   // AXI4 memory master
   , output dma_axi_pkg::axi_addr_req_s           m_axi_ar_o
   , output logic                                 m_axi_arvalid_o
   , input                                        m_axi_arready_i

   , input dma_axi_pkg::axi_data_t                m_axi_rdata_i
   , input dma_axi_pkg::axi_resp_t                m_axi_rresp_i
   , input                                        m_axi_rlast_i
   , input                                        m_axi_rvalid_i
   , output logic                                 m_axi_rready_o

   , output dma_axi_pkg::axi_addr_req_s           m_axi_aw_o
   , output logic                                 m_axi_awvalid_o
   , input                                        m_axi_awready_i

   , output dma_axi_pkg::axi_data_t               m_axi_wdata_o
   , output logic                                 m_axi_wlast_o
   , output logic                                 m_axi_wvalid_o
   , input                                        m_axi_wready_i

   , input dma_axi_pkg::axi_resp_t                m_axi_bresp_i
   , input                                        m_axi_bvalid_i
   , output logic                                 m_axi_bready_o
   );

  import dma_axi_pkg::*;

  axi_data_t wbeat_lo;
  logic      wbeat_v_lo;
  logic      wbeat_yumi_li;

  axi_data_t rbeat_lo;
  logic      rbeat_v_lo;
  logic      rbeat_ready_and_li;

  dma_block_to_beats
   #(.beats_p(beats_p))
   block_to_beats
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.block_i(dma_data_i)
     ,.block_v_i(dma_data_v_i)
     ,.block_ready_and_o(dma_data_ready_and_o)
     ,.beat_o(wbeat_lo)
     ,.beat_v_o(wbeat_v_lo)
     ,.beat_yumi_i(wbeat_yumi_li)
     );

  dma_beats_to_block
   #(.beats_p(beats_p))
   beats_to_block
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.beat_i(rbeat_lo)
     ,.beat_v_i(rbeat_v_lo)
     ,.beat_ready_and_o(rbeat_ready_and_li)
     ,.block_o(dma_data_o)
     ,.block_v_o(dma_data_v_o)
     ,.block_ready_and_i(dma_data_ready_and_i)
     );

  cache_to_axi
   #(.beats_p(beats_p))
   cache2axi
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.dma_pkt_i(dma_pkt_i)
     ,.dma_pkt_v_i(dma_pkt_v_i)
     ,.dma_pkt_ready_and_o(dma_pkt_ready_and_o)
     ,.wbeat_i(wbeat_lo)
     ,.wbeat_v_i(wbeat_v_lo)
     ,.wbeat_yumi_o(wbeat_yumi_li)
     ,.rbeat_o(rbeat_lo)
     ,.rbeat_v_o(rbeat_v_lo)
     ,.rbeat_ready_and_i(rbeat_ready_and_li)
     ,.*
     );

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds and runs the DMA AXI testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_dma_axi_top \
  -Mdir obj_dir -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "Build or run failed"; exit 1; }

grep -qx "Regression passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== tb.f ====
common/dma_axi_pkg.sv
width/dma_block_to_beats.sv
width/dma_beats_to_block.sv
cache2axi/cache_to_axi.sv
rtl/dma_axi_top.sv
tests/axi_mem_model.sv
tests/tb_dma_axi_top.sv

// ==== tests/axi_mem_model.sv ====
// Behavioral AXI4 memory slave with random ready and valid stalls
// Unwritten words read back as their byte address XORed with fill_p

`timescale 1ns/1ps

module axi_mem_model
 #(parameter logic [63:0] fill_p = '0)
  (input                                clk_i
   , input                              rst_n_i

   , input dma_axi_pkg::axi_addr_req_s  ar_i
   , input                              arvalid_i
   , output logic                       arready_o

   , output dma_axi_pkg::axi_data_t     rdata_o
   , output dma_axi_pkg::axi_resp_t     rresp_o
   , output logic                       rlast_o
   , output logic                       rvalid_o
   , input                              rready_i

   , input dma_axi_pkg::axi_addr_req_s  aw_i
   , input                              awvalid_i
   , output logic                       awready_o

   , input dma_axi_pkg::axi_data_t      wdata_i
   , input                              wlast_i
   , input                              wvalid_i
   , output logic                       wready_o

   , output dma_axi_pkg::axi_resp_t     bresp_o
   , output logic                       bvalid_o
   , input                              bready_i
   );

  import dma_axi_pkg::*;

  axi_data_t mem [dma_addr_t];

  logic          ar_hs_q, r_hs_q, aw_hs_q, w_hs_q, b_hs_q, wlast_q;
  axi_addr_req_s ar_q, aw_q;
  axi_data_t     wdata_q;
  logic          rd_active, b_pend;
  dma_addr_t     rd_ptr, wr_ptr;
  axi_len_t      rd_cnt, rd_len;

  function automatic axi_data_t read_word(input dma_addr_t addr);
    if (mem.exists(addr))
      return mem[addr];
    return 64'(addr) ^ fill_p;
  endfunction

  initial
  begin
    arready_o = 1'b0;
    rdata_o   = '0;
    rresp_o   = '0;
    rlast_o   = 1'b0;
    rvalid_o  = 1'b0;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bresp_o   = '0;
    bvalid_o  = 1'b0;
    rd_active = 1'b0;
    b_pend    = 1'b0;
  end

  // Handshakes as seen at the clock edge
  always @(posedge clk_i)
  begin
    ar_hs_q <= arvalid_i & arready_o;
    r_hs_q  <= rvalid_o & rready_i;
    aw_hs_q <= awvalid_i & awready_o;
    w_hs_q  <= wvalid_i & wready_o;
    b_hs_q  <= bvalid_o & bready_i;
    ar_q    <= ar_i;
    aw_q    <= aw_i;
    wdata_q <= wdata_i;
    wlast_q <= wlast_i;
  end

  always @(negedge clk_i)
  begin
    if (!rst_n_i)
    begin
      rvalid_o  = 1'b0;
      bvalid_o  = 1'b0;
      rd_active = 1'b0;
      b_pend    = 1'b0;
    end
    else
    begin
      if (r_hs_q)
      begin
        rvalid_o = 1'b0;
        rd_active = ~rlast_o;
        rd_ptr = rd_ptr + 32'd8;
        rd_cnt = rd_cnt + 8'd1;
      end
      if (ar_hs_q)
      begin
        rd_active = 1'b1;
        rd_ptr = ar_q.addr;
        rd_len = ar_q.len;
        rd_cnt = '0;
      end
      if (rd_active && !rvalid_o && ($urandom % 4 != 0))
      begin
        rvalid_o = 1'b1;
        rdata_o = read_word(rd_ptr);
        rlast_o = (rd_cnt == rd_len);
      end
      if (aw_hs_q)
        wr_ptr = aw_q.addr;
      if (w_hs_q)
      begin
        mem[wr_ptr] = wdata_q;
        wr_ptr = wr_ptr + 32'd8;
      end
      if (b_hs_q)
        bvalid_o = 1'b0;
      // Last W beat arms the write response
      if (w_hs_q && wlast_q)
        b_pend = 1'b1;
      if (b_pend && ($urandom % 3 != 0))
      begin
        bvalid_o = 1'b1;
        b_pend = 1'b0;
      end
    end
    arready_o = ($urandom % 2 != 0);
    awready_o = ($urandom % 2 != 0);
    wready_o  = ($urandom % 3 != 0);
  end

endmodule

// ==== tests/tb_dma_axi_top.sv ====
// Testbench for dma_axi_top against a random-stall AXI memory model
// Runs reset, directed and random mixed read/write tests

`timescale 1ns/1ps

module tb_dma_axi_top;

  import dma_axi_pkg::*;

  localparam int beats_p = 4;
  localparam logic [63:0] fill_c = 64'h5A5A_0000_C3C3_0000;
  localparam int num_tests_c = 4;
  localparam int num_trans_c = 40;
  localparam int block_bytes_c = beats_p * 8;

  logic clk_i;
  logic rst_n_i;

  dma_pkt_s                dma_pkt;
  logic                    dma_pkt_v, dma_pkt_ready_and;
  axi_data_t [beats_p-1:0] dma_wdata;
  logic                    dma_wdata_v, dma_wdata_ready_and;
  axi_data_t [beats_p-1:0] dma_rdata;
  logic                    dma_rdata_v, dma_rdata_ready_and;

  axi_addr_req_s m_axi_ar, m_axi_aw;
  logic          m_axi_arvalid, m_axi_arready, m_axi_rlast, m_axi_rvalid, m_axi_rready;
  logic          m_axi_awvalid, m_axi_awready, m_axi_wlast, m_axi_wvalid, m_axi_wready;
  logic          m_axi_bvalid, m_axi_bready;
  axi_data_t     m_axi_rdata, m_axi_wdata;
  axi_resp_t     m_axi_rresp, m_axi_bresp;

  int errors;
  int tests_run;
  axi_data_t exp_mem [dma_addr_t];

  // Handshake monitors, sampled at the edge
  logic                    pkt_hs_q, wdata_hs_q, b_hs_q, rd_done_q, busy_q;
  axi_data_t [beats_p-1:0] rd_block_q;
  dma_addr_t               acc_addr_q;
  int                      w_cnt_q;

  dma_axi_top #(.beats_p(beats_p)) dma_axi_top_i
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
     , .dma_pkt_i(dma_pkt), .dma_pkt_v_i(dma_pkt_v), .dma_pkt_ready_and_o(dma_pkt_ready_and)
     , .dma_data_i(dma_wdata), .dma_data_v_i(dma_wdata_v)
     , .dma_data_ready_and_o(dma_wdata_ready_and)
     , .dma_data_o(dma_rdata), .dma_data_v_o(dma_rdata_v)
     , .dma_data_ready_and_i(dma_rdata_ready_and)
     , .m_axi_ar_o(m_axi_ar), .m_axi_arvalid_o(m_axi_arvalid), .m_axi_arready_i(m_axi_arready)
     , .m_axi_rdata_i(m_axi_rdata), .m_axi_rresp_i(m_axi_rresp), .m_axi_rlast_i(m_axi_rlast)
     , .m_axi_rvalid_i(m_axi_rvalid), .m_axi_rready_o(m_axi_rready)
     , .m_axi_aw_o(m_axi_aw), .m_axi_awvalid_o(m_axi_awvalid), .m_axi_awready_i(m_axi_awready)
     , .m_axi_wdata_o(m_axi_wdata), .m_axi_wlast_o(m_axi_wlast)
     , .m_axi_wvalid_o(m_axi_wvalid), .m_axi_wready_i(m_axi_wready)
     , .m_axi_bresp_i(m_axi_bresp), .m_axi_bvalid_i(m_axi_bvalid), .m_axi_bready_o(m_axi_bready));

  axi_mem_model #(.fill_p(fill_c)) mem_model
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
     , .ar_i(m_axi_ar), .arvalid_i(m_axi_arvalid), .arready_o(m_axi_arready)
     , .rdata_o(m_axi_rdata), .rresp_o(m_axi_rresp), .rlast_o(m_axi_rlast)
     , .rvalid_o(m_axi_rvalid), .rready_i(m_axi_rready)
     , .aw_i(m_axi_aw), .awvalid_i(m_axi_awvalid), .awready_o(m_axi_awready)
     , .wdata_i(m_axi_wdata), .wlast_i(m_axi_wlast), .wvalid_i(m_axi_wvalid)
     , .wready_o(m_axi_wready)
     , .bresp_o(m_axi_bresp), .bvalid_o(m_axi_bvalid), .bready_i(m_axi_bready));

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    pkt_hs_q   <= dma_pkt_v & dma_pkt_ready_and;
    wdata_hs_q <= dma_wdata_v & dma_wdata_ready_and;
    b_hs_q     <= m_axi_bvalid & m_axi_bready;
    rd_done_q  <= dma_rdata_v & dma_rdata_ready_and;
    if (dma_rdata_v & dma_rdata_ready_and)
      rd_block_q <= dma_rdata;
    if (dma_pkt_v & dma_pkt_ready_and)
      acc_addr_q <= dma_pkt.addr;
    if (!rst_n_i)
      busy_q <= 1'b0;
    else if (dma_pkt_v & dma_pkt_ready_and)
      busy_q <= 1'b1;
    // A read ends when its block reaches the cache
    else if ((m_axi_bvalid & m_axi_bready) | (dma_rdata_v & dma_rdata_ready_and))
      busy_q <= 1'b0;
    if (m_axi_awvalid & m_axi_awready)
      w_cnt_q <= 0;
    else if (m_axi_wvalid & m_axi_wready)
      w_cnt_q <= w_cnt_q + 1;
  end

  always @(negedge clk_i)
    dma_rdata_ready_and <= ($urandom % 3 != 0);

  ar_shape: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_axi_arvalid |-> (m_axi_ar.len == axi_len_t'(beats_p-1) && m_axi_ar.addr == acc_addr_q))
  else
  begin
    errors++;
    $display("Error: m_axi_ar_o = %h, expected addr %h len %h", $sampled(m_axi_ar),
             $sampled(acc_addr_q), beats_p-1);
  end

  aw_shape: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_axi_awvalid |-> (m_axi_aw.len == axi_len_t'(beats_p-1) && m_axi_aw.addr == acc_addr_q))
  else
  begin
    errors++;
    $display("Error: m_axi_aw_o = %h, expected addr %h len %h", $sampled(m_axi_aw),
             $sampled(acc_addr_q), beats_p-1);
  end

  wlast_pos: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_axi_wvalid && m_axi_wready) |-> (m_axi_wlast == (w_cnt_q == beats_p-1)))
  else
  begin
    errors++;
    $display("Error: m_axi_wlast_o = %h on beat %h", $sampled(m_axi_wlast), $sampled(w_cnt_q));
  end

  w_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_axi_bvalid && m_axi_bready) |-> (w_cnt_q == beats_p))
  else
  begin
    errors++;
    $display("Error: W beat count = %h, expected %h", $sampled(w_cnt_q), beats_p);
  end

  one_pkt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_q |-> !dma_pkt_ready_and)
  else
  begin
    errors++;
    $display("Packet ready rose while a packet was still in flight");
  end

  task automatic check_idle_outputs();
    assert (!m_axi_arvalid && !m_axi_awvalid && !m_axi_wvalid && !m_axi_bready
            && !m_axi_rready && !dma_rdata_v)
    else
    begin
      errors++;
      $display("Error: outputs {ar,aw,w,b,r,data}valid/ready = %h, expected 00",
               {m_axi_arvalid, m_axi_awvalid, m_axi_wvalid, m_axi_bready,
                m_axi_rready, dma_rdata_v});
    end
  endtask

  task automatic write_block(input dma_addr_t addr, input axi_data_t [beats_p-1:0] blk);
    @(negedge clk_i);
    dma_pkt = '{write_not_read: 1'b1, addr: addr};
    dma_pkt_v = 1'b1;
    dma_wdata = blk;
    dma_wdata_v = 1'b1;
    while (dma_pkt_v || dma_wdata_v)
    begin
      @(negedge clk_i);
      if (pkt_hs_q)
        dma_pkt_v = 1'b0;
      if (wdata_hs_q)
        dma_wdata_v = 1'b0;
    end
    while (!b_hs_q)
      @(negedge clk_i);
    for (int i = 0; i < beats_p; i++)
    begin
      exp_mem[addr + dma_addr_t'(8*i)] = blk[i];
      assert (mem_model.read_word(addr + dma_addr_t'(8*i)) == blk[i])
      else
      begin
        errors++;
        $display("Error: mem[%h] = %h, expected %h", addr + dma_addr_t'(8*i),
                 mem_model.read_word(addr + dma_addr_t'(8*i)), blk[i]);
      end
    end
  endtask

  task automatic read_block(input dma_addr_t addr);
    dma_addr_t a;
    axi_data_t exp;
    @(negedge clk_i);
    dma_pkt = '{write_not_read: 1'b0, addr: addr};
    dma_pkt_v = 1'b1;
    while (dma_pkt_v)
    begin
      @(negedge clk_i);
      if (pkt_hs_q)
        dma_pkt_v = 1'b0;
    end
    while (!rd_done_q)
      @(negedge clk_i);
    for (int i = 0; i < beats_p; i++)
    begin
      a = addr + dma_addr_t'(8*i);
      exp = exp_mem.exists(a) ? exp_mem[a] : ({32'h0, a} ^ fill_c);
      assert (rd_block_q[i] == exp)
      else
      begin
        errors++;
        $display("Error: dma_data_o[%0d] = %h, expected %h", i, rd_block_q[i], exp);
      end
    end
  endtask

  function automatic dma_addr_t random_addr();
    return 32'h0001_0000 + ($urandom % 32) * block_bytes_c;
  endfunction

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    $display("Test %s: %0d errors", name, errors - err_before);
  endtask

  // Watchdog
  initial
  begin
    #(100.0 * num_tests_c * num_trans_c * 200);
    $display("Timeout, the run did not finish in time");
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    int e0;
    axi_data_t [beats_p-1:0] blk;
    dma_addr_t addr;
    void'($urandom(19715));
    errors = 0;
    tests_run = 0;
    rst_n_i = 1'b0;
    dma_pkt = '0;
    dma_pkt_v = 1'b0;
    dma_wdata = '0;
    dma_wdata_v = 1'b0;
    dma_rdata_ready_and = 1'b0;

    e0 = errors;
    repeat (2)
    begin
      @(negedge clk_i);
      check_idle_outputs();
    end
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_idle_outputs();
    report_test("reset", e0);

    e0 = errors;
    for (int i = 0; i < beats_p; i++)
      blk[i] = {$urandom, $urandom};
    write_block(32'h0000_2000, blk);
    read_block(32'h0000_2000);
    report_test("write_read", e0);

    e0 = errors;
    read_block(32'h0008_0000);
    report_test("unwritten_read", e0);

    e0 = errors;
    for (int t = 0; t < num_trans_c; t++)
    begin
      addr = random_addr();
      if ($urandom % 2 != 0)
      begin
        for (int i = 0; i < beats_p; i++)
          blk[i] = {$urandom, $urandom};
        write_block(addr, blk);
      end
      else
        read_block(addr);
    end
    report_test("random_mix", e0);

    repeat (4) @(negedge clk_i);
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== width/dma_beats_to_block.sv ====
// Gathers read beats into a block, first beat in slot 0
// Stalls the beat side while a full block waits for the cache

`timescale 1ns/1ps

module dma_beats_to_block
 #(parameter int beats_p = 4)
  (input                                          clk_i
   , input                                        rst_n_i

   , input dma_axi_pkg::axi_data_t                beat_i
   , input                                        beat_v_i
   , output logic                                 beat_ready_and_o

   , output dma_axi_pkg::axi_data_t [beats_p-1:0] block_o
   , output logic                                 block_v_o
   , input                                        block_ready_and_i
   );

  import dma_axi_pkg::*;

  localparam int cnt_width_lp = $clog2(beats_p+1);
  localparam int idx_width_lp = $clog2(beats_p);

  axi_data_t [beats_p-1:0] block_q;
  logic [cnt_width_lp-1:0] have_q;
  logic                    full;
  logic                    take;

  assign full = (have_q == cnt_width_lp'(beats_p));
  assign beat_ready_and_o = ~full;
  assign take = beat_v_i & beat_ready_and_o;

  assign block_o = block_q;
  assign block_v_o = full;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      have_q <= '0;
    else if (block_v_o & block_ready_and_i)
      have_q <= '0;
    else if (take)
      have_q <= have_q + cnt_width_lp'(1);
  end

  // Count doubles as the write slot while filling
  always_ff @(posedge clk_i)
  begin
    if (take)
      block_q[have_q[idx_width_lp-1:0]] <= beat_i;
  end

endmodule

// ==== width/dma_block_to_beats.sv ====
// Splits a write block into AXI beats, low beat first
// Takes a new block only once the previous one has fully drained

`timescale 1ns/1ps

module dma_block_to_beats
 #(parameter int beats_p = 4)
  (input                                         clk_i
   , input                                       rst_n_i

   , input dma_axi_pkg::axi_data_t [beats_p-1:0] block_i
   , input                                       block_v_i
   , output logic                                block_ready_and_o

   , output dma_axi_pkg::axi_data_t              beat_o
   , output logic                                beat_v_o
   , input                                       beat_yumi_i
   );

  import dma_axi_pkg::*;

  localparam int cnt_width_lp = $clog2(beats_p+1);

  axi_data_t [beats_p-1:0] shift_q;
  logic [cnt_width_lp-1:0] left_q;
  logic                    load;

  assign block_ready_and_o = (left_q == '0);
  assign load = block_v_i & block_ready_and_o;

  assign beat_o = shift_q[0];
  assign beat_v_o = (left_q != '0);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      left_q <= '0;
    else if (load)
      left_q <= cnt_width_lp'(beats_p);
    else if (beat_yumi_i)
      left_q <= left_q - cnt_width_lp'(1);
  end

  // Next beat moves down into slot 0 on each yumi
  always_ff @(posedge clk_i)
  begin
    if (load)
      shift_q <= block_i;
    else if (beat_yumi_i)
      shift_q <= {axi_data_t'('0), shift_q[beats_p-1:1]};
  end

endmodule
